//--- logic/rank_filter_pkg.sv
package rank_filter_pkg;

  // sample width used when the top level is not overridden
  localparam int DATA_W_DEF = 8;

  // window length, fixed by the structure of the 7-key sorter
  localparam int WIN_N = 7;

  // register stages from input strobe to output strobe
  localparam int SORT5_LAT = 3;
  localparam int SORT7_LAT = 10;

  // OP_RANK takes its index from a separate 3-bit rank input
  typedef enum logic [1:0] {
    OP_MIN,
    OP_MEDIAN,
    OP_MAX,
    OP_RANK
  } rank_op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FILL,
    ST_RUN
  } ctrl_state_e;

endpackage

//--- logic/sort_bus_if.sv
interface sort_bus_if import rank_filter_pkg::*; #(
  parameter int DATA_W = DATA_W_DEF
);

  // key 0 is the newest sample before the sort, the minimum after it
  logic [DATA_W-1:0] key [WIN_N];
  logic              strobe;

  modport producer (
    output key,
    output strobe
  );

  modport consumer (
    input key,
    input strobe
  );

  // the unsorted window bus has its keys and its strobe from two modules
  modport key_producer (
    output key
  );

  modport strobe_producer (
    output strobe
  );

endinterface

//--- logic/sorting_network.sv
module sorting_network import rank_filter_pkg::*; #(
  parameter int DATA_W = DATA_W_DEF
) (
  input  logic [DATA_W-1:0] s1_i,
  input  logic [DATA_W-1:0] s2_i,
  input  logic [DATA_W-1:0] s3_i,
  output logic [DATA_W-1:0] min_o,
  output logic [DATA_W-1:0] med_o,
  output logic [DATA_W-1:0] max_o
);

  logic [DATA_W-1:0] pair_lo;
  logic [DATA_W-1:0] pair_hi;
  logic [DATA_W-1:0] rest;

  // order the first pair
  assign pair_lo = (s1_i < s2_i) ? s1_i : s2_i;
  assign pair_hi = (s1_i < s2_i) ? s2_i : s1_i;

  // larger of pair_hi and s3 is the max, the other one goes on
  assign max_o = (pair_hi > s3_i) ? pair_hi : s3_i;
  assign rest  = (pair_hi > s3_i) ? s3_i : pair_hi;

  assign min_o = (pair_lo < rest) ? pair_lo : rest;
  assign med_o = (pair_lo < rest) ? rest : pair_lo;

endmodule

//--- logic/sort_ascending_5.sv
module sort_ascending_5 import rank_filter_pkg::*; #(
  parameter int DATA_W = DATA_W_DEF
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   strobe_i,
  output logic                   strobe_o,
  input  logic [4:0][DATA_W-1:0] keys_i,
  output logic [DATA_W-1:0]      min_o,
  output logic [DATA_W-1:0]      out2_o,
  output logic [DATA_W-1:0]      mid_o,
  output logic [DATA_W-1:0]      out4_o,
  output logic [DATA_W-1:0]      max_o
);

  typedef logic [4:0][DATA_W-1:0] key5_t;

  key5_t                st1_d, st1_q;
  key5_t                st2_d, st2_q;
  key5_t                st3_d, st3_q;
  logic [SORT5_LAT-1:0] strobe_q;

  function automatic key5_t cmp_swap(key5_t v, int lo, int hi);
    key5_t r;
    r = v;
    if (v[lo] > v[hi]) begin
      r[lo] = v[hi];
      r[hi] = v[lo];
    end
    return r;
  endfunction

  // 9-comparator network, three comparators per register stage
  // stage 1 sorts keys 0..1 and starts on keys 2..4
  always_comb begin
    key5_t v;
    v = cmp_swap(keys_i, 0, 1);
    v = cmp_swap(v, 3, 4);
    st1_d = cmp_swap(v, 2, 4);
  end

  // keys 2..4 finish sorting, then the minimum settles in key 0
  always_comb begin
    key5_t v;
    v = cmp_swap(st1_q, 2, 3);
    v = cmp_swap(v, 0, 3);
    st2_d = cmp_swap(v, 0, 2);
  end

  always_comb begin
    key5_t v;
    v = cmp_swap(st2_q, 1, 4);
    v = cmp_swap(v, 1, 3);
    st3_d = cmp_swap(v, 1, 2);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      st1_q    <= '0;
      st2_q    <= '0;
      st3_q    <= '0;
      strobe_q <= '0;
    end else begin
      st1_q    <= st1_d;
      st2_q    <= st2_d;
      st3_q    <= st3_d;
      strobe_q <= {strobe_q[SORT5_LAT-2:0], strobe_i};
    end
  end

  assign min_o    = st3_q[0];
  assign out2_o   = st3_q[1];
  assign mid_o    = st3_q[2];
  assign out4_o   = st3_q[3];
  assign max_o    = st3_q[4];
  assign strobe_o = strobe_q[SORT5_LAT-1];

endmodule

//--- logic/sort_ascending_7.sv
module sort_ascending_7 import rank_filter_pkg::*; #(
  parameter int DATA_W = DATA_W_DEF
) (
  input  logic        clk,
  input  logic        rst_n,
  sort_bus_if.consumer in_bus,
  sort_bus_if.producer out_bus
);

  logic [4:0][DATA_W-1:0] sa1_out, sa1_q;
  logic [4:0][DATA_W-1:0] sa2_out, sa2_q;
  logic                   sa1_strobe, sa2_strobe;

  // keys 5 and 6 wait for SA1 and its output register
  logic [1:0][DATA_W-1:0] tail_dly [SORT5_LAT+1];
  // SA1's two lowest keys wait for SA2
  logic [1:0][DATA_W-1:0] low_dly [SORT5_LAT];

  logic [1:0][DATA_W-1:0] p2_low;
  logic [DATA_W-1:0]      sn1_min, sn1_med, sn1_max;
  logic [DATA_W-1:0]      p3_sn1_min, p3_sn1_med, p3_sn1_max;
  logic [4:1][DATA_W-1:0] p3_sa2;
  logic [DATA_W-1:0]      sn2_min, sn2_med, sn2_max;
  logic [DATA_W-1:0]      p4_sn1_min, p4_sn2_min, p4_sn2_med, p4_sn2_max;
  logic [4:2][DATA_W-1:0] p4_sa2;
  logic                   p1_strobe, p2_strobe, p3_strobe, p4_strobe;

  sort_ascending_5 #(.DATA_W(DATA_W)) i_sa1 (
    .clk      (clk),
    .rst_n    (rst_n),
    .strobe_i (in_bus.strobe),
    .strobe_o (sa1_strobe),
    .keys_i   ({in_bus.key[4], in_bus.key[3], in_bus.key[2], in_bus.key[1], in_bus.key[0]}),
    .min_o    (sa1_out[0]),
    .out2_o   (sa1_out[1]),
    .mid_o    (sa1_out[2]),
    .out4_o   (sa1_out[3]),
    .max_o    (sa1_out[4])
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i <= SORT5_LAT; i++) begin
        tail_dly[i] <= '0;
      end
      for (int i = 0; i < SORT5_LAT; i++) begin
        low_dly[i] <= '0;
      end
      sa1_q     <= '0;
      p1_strobe <= 1'b0;
    end else begin
      tail_dly[0] <= {in_bus.key[6], in_bus.key[5]};
      for (int i = 1; i <= SORT5_LAT; i++) begin
        tail_dly[i] <= tail_dly[i-1];
      end
      low_dly[0] <= sa1_q[1:0];
      for (int i = 1; i < SORT5_LAT; i++) begin
        low_dly[i] <= low_dly[i-1];
      end
      sa1_q     <= sa1_out;
      p1_strobe <= sa1_strobe;
    end
  end

  // top three of SA1 meet the two delayed keys; SA2's top three are final
  sort_ascending_5 #(.DATA_W(DATA_W)) i_sa2 (
    .clk      (clk),
    .rst_n    (rst_n),
    .strobe_i (p1_strobe),
    .strobe_o (sa2_strobe),
    .keys_i   ({sa1_q[2], sa1_q[3], sa1_q[4], tail_dly[SORT5_LAT]}),
    .min_o    (sa2_out[0]),
    .out2_o   (sa2_out[1]),
    .mid_o    (sa2_out[2]),
    .out4_o   (sa2_out[3]),
    .max_o    (sa2_out[4])
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      p2_low    <= '0;
      sa2_q     <= '0;
      p2_strobe <= 1'b0;
    end else begin
      p2_low    <= low_dly[SORT5_LAT-1];
      sa2_q     <= sa2_out;
      p2_strobe <= sa2_strobe;
    end
  end

  // merge the four lowest candidates
  sorting_network #(.DATA_W(DATA_W)) i_sn1 (
    .s1_i  (p2_low[0]),
    .s2_i  (p2_low[1]),
    .s3_i  (sa2_q[0]),
    .min_o (sn1_min),
    .med_o (sn1_med),
    .max_o (sn1_max)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      p3_sn1_min <= '0;
      p3_sn1_med <= '0;
      p3_sn1_max <= '0;
      p3_sa2     <= '0;
      p3_strobe  <= 1'b0;
    end else begin
      p3_sn1_min <= sn1_min;
      p3_sn1_med <= sn1_med;
      p3_sn1_max <= sn1_max;
      p3_sa2     <= sa2_q[4:1];
      p3_strobe  <= p2_strobe;
    end
  end

  // sn2 max is the fourth smallest
  sorting_network #(.DATA_W(DATA_W)) i_sn2 (
    .s1_i  (p3_sn1_med),
    .s2_i  (p3_sn1_max),
    .s3_i  (p3_sa2[1]),
    .min_o (sn2_min),
    .med_o (sn2_med),
    .max_o (sn2_max)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      p4_sn1_min <= '0;
      p4_sn2_min <= '0;
      p4_sn2_med <= '0;
      p4_sn2_max <= '0;
      p4_sa2     <= '0;
      p4_strobe  <= 1'b0;
    end else begin
      p4_sn1_min <= p3_sn1_min;
      p4_sn2_min <= sn2_min;
      p4_sn2_med <= sn2_med;
      p4_sn2_max <= sn2_max;
      p4_sa2     <= p3_sa2[4:2];
      p4_strobe  <= p3_strobe;
    end
  end

  // last network is combinational into the three lowest outputs
  sorting_network #(.DATA_W(DATA_W)) i_sn3 (
    .s1_i  (p4_sn1_min),
    .s2_i  (p4_sn2_med),
    .s3_i  (p4_sn2_min),
    .min_o (out_bus.key[0]),
    .med_o (out_bus.key[1]),
    .max_o (out_bus.key[2])
  );

  assign out_bus.key[3] = p4_sn2_max;
  assign out_bus.key[4] = p4_sa2[2];
  assign out_bus.key[5] = p4_sa2[3];
  assign out_bus.key[6] = p4_sa2[4];
  assign out_bus.strobe = p4_strobe;

endmodule

//--- logic/window_shift.sv
module window_shift import rank_filter_pkg::*; #(
  parameter int DATA_W = DATA_W_DEF
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              sample_valid_i,
  input  logic [DATA_W-1:0] sample_i,
  sort_bus_if.key_producer  win_bus
);

  logic [DATA_W-1:0] taps [WIN_N];

  // newest sample enters at tap 0, the oldest drops off the end
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < WIN_N; i++) begin
        taps[i] <= '0;
      end
    end else if (sample_valid_i) begin
      taps[0] <= sample_i;
      for (int i = 1; i < WIN_N; i++) begin
        taps[i] <= taps[i-1];
      end
    end
  end

  // stale taps after a flush are harmless, no strobe until the window refills
  assign win_bus.key = taps;

endmodule

//--- logic/rank_filter_ctrl.sv
module rank_filter_ctrl import rank_filter_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                sample_valid_i,
  input  logic                flush_i,
  input  rank_op_e            op_i,
  input  logic [2:0]          rank_i,
  sort_bus_if.strobe_producer win_bus,
  output rank_op_e            sel_op_o,
  output logic [2:0]          sel_rank_o
);

  localparam int CNT_W = $clog2(WIN_N + 1);

  ctrl_state_e      state;
  logic [CNT_W-1:0] fill_cnt;
  logic             win_strobe_q;

  // stage 0 lines up with the window strobe, the rest with the sorter
  rank_op_e   op_pipe [SORT7_LAT+1];
  logic [2:0] rank_pipe [SORT7_LAT+1];

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      state        <= ST_IDLE;
      fill_cnt     <= '0;
      win_strobe_q <= 1'b0;
    end else begin
      win_strobe_q <= sample_valid_i &&
                      (state == ST_RUN || fill_cnt == CNT_W'(WIN_N - 1));
      if (sample_valid_i) begin
        unique case (state)
          ST_IDLE: begin
            state    <= ST_FILL;
            fill_cnt <= CNT_W'(1);
          end
          ST_FILL: begin
            fill_cnt <= fill_cnt + 1'b1;
            if (fill_cnt == CNT_W'(WIN_N - 1)) begin
              state <= ST_RUN;
            end
          end
          ST_RUN: begin
            // window stays full, count parks at WIN_N
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i <= SORT7_LAT; i++) begin
        op_pipe[i]   <= OP_MIN;
        rank_pipe[i] <= '0;
      end
    end else begin
      op_pipe[0]   <= op_i;
      rank_pipe[0] <= rank_i;
      for (int i = 1; i <= SORT7_LAT; i++) begin
        op_pipe[i]   <= op_pipe[i-1];
        rank_pipe[i] <= rank_pipe[i-1];
      end
    end
  end

  assign win_bus.strobe = win_strobe_q;
  assign sel_op_o       = op_pipe[SORT7_LAT];
  assign sel_rank_o     = rank_pipe[SORT7_LAT];

endmodule

//--- logic/rank_select.sv
module rank_select import rank_filter_pkg::*; #(
  parameter int DATA_W = DATA_W_DEF
) (
  input  logic              clk,
  input  logic              rst_n,
  sort_bus_if.consumer      sorted_bus,
  input  rank_op_e          sel_op_i,
  input  logic [2:0]        sel_rank_i,
  output logic              result_valid_o,
  output logic [DATA_W-1:0] result_o
);

  logic [2:0] sel_idx;

  always_comb begin
    unique case (sel_op_i)
      OP_MIN:    sel_idx = 3'd0;
      OP_MEDIAN: sel_idx = 3'(WIN_N / 2);
      OP_MAX:    sel_idx = 3'(WIN_N - 1);
      // out of range ranks clamp to the max
      OP_RANK:   sel_idx = (sel_rank_i > 3'(WIN_N - 1)) ? 3'(WIN_N - 1) : sel_rank_i;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid_o <= 1'b0;
      result_o       <= '0;
    end else begin
      result_valid_o <= sorted_bus.strobe;
      // hold the last result between strobes
      if (sorted_bus.strobe) begin
        result_o <= sorted_bus.key[sel_idx];
      end
    end
  end

endmodule

//--- logic/rank_filter_top.sv
module rank_filter_top import rank_filter_pkg::*; #(
  parameter int DATA_W = DATA_W_DEF
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              sample_valid_i,
  input  logic              flush_i,
  input  logic [DATA_W-1:0] sample_i,
  input  rank_op_e          op_i,
  input  logic [2:0]        rank_i,
  output logic              result_valid_o,
  output logic [DATA_W-1:0] result_o
);

  rank_op_e   sel_op;
  logic [2:0] sel_rank;

  sort_bus_if #(.DATA_W(DATA_W)) win_bus ();
  sort_bus_if #(.DATA_W(DATA_W)) sorted_bus ();

  rank_filter_ctrl i_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .sample_valid_i (sample_valid_i),
    .flush_i        (flush_i),
    .op_i           (op_i),
    .rank_i         (rank_i),
    .win_bus        (win_bus.strobe_producer),
    .sel_op_o       (sel_op),
    .sel_rank_o     (sel_rank)
  );

  window_shift #(.DATA_W(DATA_W)) i_window (
    .clk            (clk),
    .rst_n          (rst_n),
    .sample_valid_i (sample_valid_i),
    .sample_i       (sample_i),
    .win_bus        (win_bus.key_producer)
  );

  sort_ascending_7 #(.DATA_W(DATA_W)) i_sort7 (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_bus  (win_bus.consumer),
    .out_bus (sorted_bus.producer)
  );

  rank_select #(.DATA_W(DATA_W)) i_select (
    .clk            (clk),
    .rst_n          (rst_n),
    .sorted_bus     (sorted_bus.consumer),
    .sel_op_i       (sel_op),
    .sel_rank_i     (sel_rank),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

endmodule

//--- verification/rank_filter_tb.sv
module rank_filter_tb import rank_filter_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DATA_W = DATA_W_DEF;
  // accepting edge to the edge that sees result_valid_o
  localparam int LATENCY = 12;
  localparam logic [15:0] SEED = 16'd62544;
  // reset, fill, stream, op cycle, rank, gaps, flush, then margin
  localparam int MAX_CYCLES = 8 + 40 + 220 + 50 + 35 + 170 + 90 + 100;

  logic              clk;
  logic              rst_n;
  logic              sample_valid_i;
  logic              flush_i;
  logic [DATA_W-1:0] sample_i;
  rank_op_e          op_i;
  logic [2:0]        rank_i;
  logic              result_valid_o;
  logic [DATA_W-1:0] result_o;

  logic [15:0]       lfsr_state;
  int                cyc = 0;
  int                got_cnt = 0;
  int                max_in_flight = 0;

  // reference window, entry 0 is the newest sample
  logic [DATA_W-1:0] ref_win [WIN_N];
  int                ref_cnt = 0;
  logic [DATA_W-1:0] exp_val_q [$];
  int                exp_due_q [$];

  rank_filter_top #(.DATA_W(DATA_W)) i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .sample_valid_i (sample_valid_i),
    .flush_i        (flush_i),
    .sample_i       (sample_i),
    .op_i           (op_i),
    .rank_i         (rank_i),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0d ns: %s = 0x%0h, expected 0x%0h",
                          $time, name, got, exp));
    end
  endtask

  // galois form, taps 16 14 13 11
  function automatic logic [7:0] rand_bits(int n);
    logic [7:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[6:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
    end
    return r;
  endfunction

  function automatic logic [DATA_W-1:0] ranked_value(rank_op_e op, logic [2:0] rk);
    logic [DATA_W-1:0] srt [WIN_N];
    logic [DATA_W-1:0] tmp;
    int                idx;
    for (int i = 0; i < WIN_N; i++) begin
      srt[i] = ref_win[i];
    end
    for (int i = 0; i < WIN_N - 1; i++) begin
      for (int j = 0; j < WIN_N - 1 - i; j++) begin
        if (srt[j] > srt[j+1]) begin
          tmp      = srt[j];
          srt[j]   = srt[j+1];
          srt[j+1] = tmp;
        end
      end
    end
    case (op)
      OP_MIN:    idx = 0;
      OP_MEDIAN: idx = 3;
      OP_MAX:    idx = 6;
      default:   idx = (rk > 3'd6) ? 6 : int'(rk);
    endcase
    return srt[idx];
  endfunction

  task automatic check_output();
    if (result_valid_o) begin
      if (exp_due_q.size() == 0 || exp_due_q[0] != cyc) begin
        abort_run($sformatf("result at %0d ns where no result was expected", $time));
      end else begin
        check_value("result_o", 32'(result_o), 32'(exp_val_q[0]));
        void'(exp_val_q.pop_front());
        void'(exp_due_q.pop_front());
        got_cnt++;
      end
    end else if (exp_due_q.size() != 0 && exp_due_q[0] == cyc) begin
      abort_run($sformatf("expected result did not arrive at %0d ns", $time));
    end
  endtask

  // flush clears the count but the sample on the same edge still shifts in
  task automatic update_model();
    if (flush_i) begin
      ref_cnt = 0;
    end
    if (sample_valid_i) begin
      for (int i = WIN_N - 1; i > 0; i--) begin
        ref_win[i] = ref_win[i-1];
      end
      ref_win[0] = sample_i;
      if (!flush_i) begin
        if (ref_cnt < WIN_N) begin
          ref_cnt++;
        end
        if (ref_cnt == WIN_N) begin
          exp_val_q.push_back(ranked_value(op_i, rank_i));
          exp_due_q.push_back(cyc + LATENCY);
          if (exp_due_q.size() > max_in_flight) begin
            max_in_flight = exp_due_q.size();
          end
        end
      end
    end
  endtask

  // inputs and outputs are read before this edge's updates land
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc > MAX_CYCLES) begin
      abort_run($sformatf("timeout after %0d cycles, the tests did not finish", cyc));
    end else if (!rst_n) begin
      ref_cnt = 0;
    end else begin
      check_output();
      update_model();
    end
  end

  task automatic drive(logic valid, logic [DATA_W-1:0] smp, logic flush,
                       rank_op_e op, logic [2:0] rk);
    @(posedge clk);
    sample_valid_i <= valid;
    sample_i       <= smp;
    flush_i        <= flush;
    op_i           <= op;
    rank_i         <= rk;
  endtask

  task automatic idle_cycles(int n);
    repeat (n) drive(1'b0, '0, 1'b0, OP_MEDIAN, 3'd0);
    @(negedge clk);
  endtask

  task automatic drain_results();
    drive(1'b0, '0, 1'b0, OP_MEDIAN, 3'd0);
    @(negedge clk);
    while (exp_due_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic test_fill();
    logic [DATA_W-1:0] vals [WIN_N] = '{8'd50, 8'd10, 8'd200, 8'd30, 8'd90, 8'd70, 8'd120};
    int                cnt0;
    cnt0 = got_cnt;
    for (int i = 0; i < WIN_N - 1; i++) begin
      drive(1'b1, vals[i], 1'b0, OP_MEDIAN, 3'd0);
    end
    idle_cycles(LATENCY + 2);
    check_value("result count", 32'(got_cnt - cnt0), 32'd0);
    drive(1'b1, vals[WIN_N-1], 1'b0, OP_MEDIAN, 3'd0);
    drain_results();
    check_value("result count", 32'(got_cnt - cnt0), 32'd1);
    check_value("result_o", 32'(result_o), 32'd70);
  endtask

  task automatic test_stream();
    int cnt0;
    cnt0 = got_cnt;
    drive(1'b0, '0, 1'b1, OP_MEDIAN, 3'd0);
    for (int i = 0; i < 200; i++) begin
      drive(1'b1, rand_bits(8), 1'b0, OP_MEDIAN, 3'd0);
    end
    drain_results();
    check_value("result count", 32'(got_cnt - cnt0), 32'd194);
    if (max_in_flight < 10) begin
      abort_run($sformatf("only %0d windows were in flight at once", max_in_flight));
    end
  endtask

  task automatic test_op_cycle();
    rank_op_e ops [3] = '{OP_MIN, OP_MEDIAN, OP_MAX};
    int       cnt0;
    cnt0 = got_cnt;
    for (int i = 0; i < 30; i++) begin
      drive(1'b1, rand_bits(8), 1'b0, ops[i % 3], 3'd0);
    end
    drain_results();
    check_value("result count", 32'(got_cnt - cnt0), 32'd30);
  endtask

  // a cyclic pattern keeps the same values in the window once it is full
  task automatic test_rank();
    logic [DATA_W-1:0] pat [WIN_N] = '{8'd40, 8'd7, 8'd255, 8'd40, 8'd0, 8'd128, 8'd7};
    int                cnt0;
    cnt0 = got_cnt;
    for (int i = 0; i < WIN_N + 8; i++) begin
      drive(1'b1, pat[i % WIN_N], 1'b0, OP_RANK, 3'((i < WIN_N) ? 0 : i - WIN_N));
    end
    drain_results();
    check_value("result count", 32'(got_cnt - cnt0), 32'd15);
    check_value("result_o", 32'(result_o), 32'd255);
  endtask

  task automatic test_gaps();
    logic [7:0] v;
    int         cnt0;
    int         n_valid;
    cnt0    = got_cnt;
    n_valid = 0;
    for (int i = 0; i < 150; i++) begin
      v = rand_bits(1);
      n_valid += int'(v[0]);
      drive(v[0], rand_bits(8), 1'b0, OP_MEDIAN, 3'd0);
    end
    drain_results();
    check_value("result count", 32'(got_cnt - cnt0), 32'(n_valid));
  endtask

  task automatic test_flush();
    int cnt0;
    cnt0 = got_cnt;
    for (int i = 0; i < 20; i++) begin
      drive(1'b1, rand_bits(8), 1'b0, OP_MEDIAN, 3'd0);
    end
    drive(1'b1, rand_bits(8), 1'b1, OP_MEDIAN, 3'd0);
    for (int i = 0; i < WIN_N - 1; i++) begin
      drive(1'b1, rand_bits(8), 1'b0, OP_MEDIAN, 3'd0);
    end
    idle_cycles(LATENCY + 2);
    check_value("result count", 32'(got_cnt - cnt0), 32'd20);
    for (int i = 0; i < WIN_N; i++) begin
      drive(1'b1, rand_bits(8), 1'b0, OP_MAX, 3'd0);
    end
    drain_results();
    check_value("result count", 32'(got_cnt - cnt0), 32'd27);
    drive(1'b0, '0, 1'b1, OP_MEDIAN, 3'd0);
    for (int i = 0; i < 3; i++) begin
      drive(1'b1, rand_bits(8), 1'b0, OP_MEDIAN, 3'd0);
    end
    idle_cycles(LATENCY + 2);
    check_value("result count", 32'(got_cnt - cnt0), 32'd27);
  endtask

  initial begin
    rst_n          = 1'b0;
    sample_valid_i = 1'b0;
    flush_i        = 1'b0;
    sample_i       = '0;
    op_i           = OP_MEDIAN;
    rank_i         = 3'd0;
    lfsr_state     = SEED;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    test_fill();
    test_stream();
    test_op_cycle();
    test_rank();
    test_gaps();
    test_flush();
    if (exp_due_q.size() == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      abort_run("expected results were still pending at the end of the run");
    end
  end

endmodule

//--- compile.f
logic/rank_filter_pkg.sv
logic/sort_bus_if.sv
logic/sorting_network.sv
logic/sort_ascending_5.sv
logic/sort_ascending_7.sv
logic/window_shift.sv
logic/rank_filter_ctrl.sv
logic/rank_select.sv
logic/rank_filter_top.sv
verification/rank_filter_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the rank filter testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -f compile.f --top-module rank_filter_tb \
  --Mdir "$build_dir" -o rank_filter_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/rank_filter_sim" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "SIMULATION FAILED" "$log_file"; then
  echo "simulation reported a failure, see $log_file"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

echo "simulation finished without failures"
exit 0
